// ==== rtl/core_cfg.svh ====
// core configuration constants for the 16-bit teaching CPU.
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data path and address width.
`define CORE_DATA_WIDTH 16

// number of general purpose registers.
`define CORE_REG_COUNT 8

// address of the first instruction fetched after reset.
`define CORE_RESET_PC 16'h0000

`endif

// ==== rtl/corePkg.sv ====
// shared types for the sequencer, decoder and execution units of the CPU core.
`default_nettype none

package corePkg;

	// sequencer state, one phase per cycle.
	typedef enum logic [2:0] {
		phaseFetch,
		phaseDecode,
		phaseExecute,
		phaseCommit,
		phaseStopped
	} phaseT;

	// instruction group, bits 15..14 of the word.
	typedef enum logic [1:0] {
		groupAlu,
		groupLoadStore,
		groupJump,
		groupGeneral
	} groupT;

	// alu operation, bits 13..11 in the alu group.
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluMov,
		aluShl,
		aluShr
	} aluOpT;

	// memory operation, taken from bits 13..12 in the load/store group.
	typedef enum logic [1:0] {
		memNone,
		memLoadImm,
		memLoad,
		memStore
	} memOpT;

	// jump condition, bits 13..12 in the jump group.
	typedef enum logic [1:0] {
		condAlways,
		condZero,
		condCarry,
		condSign
	} condT;

endpackage

`default_nettype wire

// ==== rtl/phaseSequencer.sv ====
// four-phase instruction sequencer with a stopped state entered on halt.
`timescale 1ns/10ps
`default_nettype none

module phaseSequencer
	import corePkg::*;
(
	input wire logic CLK,
	input wire logic arstN,
	input wire logic haltReq,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,
	output logic stopped
);

	phaseT state;
	// low for the reset cycle so no strobe fires until reset is released.
	logic running;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state <= phaseFetch;
			running <= 1'b0;
		end else if (!running) begin
			running <= 1'b1;
		end else begin
			case (state)
				phaseFetch: state <= phaseDecode;
				phaseDecode: state <= phaseExecute;
				phaseExecute: state <= phaseCommit;
				// halt takes effect once its own commit is done.
				phaseCommit: state <= haltReq ? phaseStopped : phaseFetch;
				phaseStopped: state <= phaseStopped;
				default: state <= phaseFetch;
			endcase
		end
	end

	assign fetch = running && (state == phaseFetch);
	assign decode = (state == phaseDecode);
	assign execute = (state == phaseExecute);
	assign commit = (state == phaseCommit);
	assign stopped = (state == phaseStopped);

endmodule

`default_nettype wire

// ==== rtl/instructionDecoder.sv ====
// instruction latch and decoder producing registered control fields.
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module instructionDecoder
	import corePkg::*;
#(
	parameter int regAddrWidth = $clog2(`CORE_REG_COUNT)
) (
	input wire logic CLK,
	input wire logic arstN,
	input wire logic fetch,
	input wire logic [`CORE_DATA_WIDTH-1:0] instrWord,
	output groupT group,
	output aluOpT aluOp,
	output memOpT memOp,
	output condT cond,
	output logic [regAddrWidth-1:0] regA,
	output logic [regAddrWidth-1:0] regB,
	output logic [`CORE_DATA_WIDTH-1:0] immediate,
	output logic [`CORE_DATA_WIDTH-1:0] offset,
	output logic regWrite,
	output logic haltReq
);

	groupT nextGroup;
	memOpT nextMemOp;
	logic [regAddrWidth-1:0] nextRegA;
	logic nextRegWrite;
	logic nextHalt;

	always_comb begin
		nextGroup = groupT'(instrWord[15:14]);
		nextMemOp = memNone;
		nextRegA = instrWord[5:3];
		nextRegWrite = 1'b0;
		nextHalt = 1'b0;
		case (nextGroup)
			groupAlu: nextRegWrite = 1'b1;
			groupLoadStore: begin
				case (instrWord[13:12])
					2'd0: begin
						// load immediate keeps its destination in 10..8.
						nextMemOp = memLoadImm;
						nextRegA = instrWord[10:8];
						nextRegWrite = 1'b1;
					end
					2'd1: begin
						nextMemOp = memLoad;
						nextRegWrite = 1'b1;
					end
					2'd2: nextMemOp = memStore;
					default: nextMemOp = memNone;
				endcase
			end
			groupGeneral: nextHalt = (instrWord[13:12] == 2'd1);
			default: nextRegWrite = 1'b0;
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			group <= groupGeneral;
			aluOp <= aluAdd;
			memOp <= memNone;
			cond <= condAlways;
			regA <= '0;
			regB <= '0;
			immediate <= '0;
			offset <= '0;
			regWrite <= 1'b0;
			haltReq <= 1'b0;
		end else if (fetch) begin
			group <= nextGroup;
			aluOp <= aluOpT'(instrWord[13:11]);
			memOp <= nextMemOp;
			cond <= condT'(instrWord[13:12]);
			regA <= nextRegA;
			regB <= instrWord[2:0];
			immediate <= {{(`CORE_DATA_WIDTH-8){1'b0}}, instrWord[7:0]};
			offset <= {{(`CORE_DATA_WIDTH-8){instrWord[7]}}, instrWord[7:0]};
			regWrite <= nextRegWrite;
			haltReq <= nextHalt;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
// alu with registered zero, carry and sign condition flags.
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module alu
	import corePkg::*;
(
	input wire logic CLK,
	input wire logic arstN,
	input wire logic commit,
	input wire logic aluEn,
	input wire aluOpT aluOp,
	input wire logic [`CORE_DATA_WIDTH-1:0] aData,
	input wire logic [`CORE_DATA_WIDTH-1:0] bData,
	output logic [`CORE_DATA_WIDTH-1:0] result,
	output logic flagZero,
	output logic flagCarry,
	output logic flagSign
);

	logic carryOut;
	// shift distance comes from the low four bits of rB.
	logic [3:0] shiftAmount;

	assign shiftAmount = bData[3:0];

	always_comb begin
		carryOut = 1'b0;
		case (aluOp)
			aluAdd: {carryOut, result} = {1'b0, aData} + {1'b0, bData};
			// bit 16 of the difference is the unsigned borrow.
			aluSub: {carryOut, result} = {1'b0, aData} - {1'b0, bData};
			aluAnd: result = aData & bData;
			aluOr: result = aData | bData;
			aluXor: result = aData ^ bData;
			aluMov: result = bData;
			// the extra bit catches the last bit shifted out.
			aluShl: {carryOut, result} = {1'b0, aData} << shiftAmount;
			aluShr: {result, carryOut} = {aData, 1'b0} >> shiftAmount;
			default: result = aData;
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			flagZero <= 1'b0;
			flagCarry <= 1'b0;
			flagSign <= 1'b0;
		end else if (commit && aluEn) begin
			flagZero <= (result == '0);
			flagCarry <= carryOut;
			flagSign <= result[`CORE_DATA_WIDTH-1];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/registerFile.sv ====
// register file with two combinational read ports and one write port.
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module registerFile #(
	parameter int regAddrWidth = $clog2(`CORE_REG_COUNT)
) (
	input wire logic CLK,
	input wire logic arstN,
	input wire logic wrEn,
	input wire logic [regAddrWidth-1:0] wrAddr,
	input wire logic [regAddrWidth-1:0] rdAddrA,
	input wire logic [regAddrWidth-1:0] rdAddrB,
	input wire logic [`CORE_DATA_WIDTH-1:0] wrData,
	output logic [`CORE_DATA_WIDTH-1:0] rdDataA,
	output logic [`CORE_DATA_WIDTH-1:0] rdDataB
);

	logic [`CORE_DATA_WIDTH-1:0] regs [`CORE_REG_COUNT];

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `CORE_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

// ==== rtl/programCounter.sv ====
// program counter with conditional relative jumps.
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module programCounter
	import corePkg::*;
(
	input wire logic CLK,
	input wire logic arstN,
	input wire logic commit,
	input wire logic isJump,
	input wire condT cond,
	input wire logic [`CORE_DATA_WIDTH-1:0] offset,
	input wire logic flagZero,
	input wire logic flagCarry,
	input wire logic flagSign,
	output logic [`CORE_DATA_WIDTH-1:0] pc
);

	logic condMet;
	logic [`CORE_DATA_WIDTH-1:0] nextPc;

	always_comb begin
		case (cond)
			condZero: condMet = flagZero;
			condCarry: condMet = flagCarry;
			condSign: condMet = flagSign;
			default: condMet = 1'b1;
		endcase
	end

	// offset is relative to the word after the jump.
	assign nextPc = pc + `CORE_DATA_WIDTH'(1) + ((isJump && condMet) ? offset : '0);

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			pc <= `CORE_RESET_PC;
		end else if (commit) begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/busController.sv ====
// memory bus controller for instruction fetch, load and store.
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module busController
	import corePkg::*;
(
	input wire logic CLK,
	input wire logic arstN,
	input wire logic fetch,
	input wire logic execute,
	input wire memOpT memOp,
	input wire logic [`CORE_DATA_WIDTH-1:0] pc,
	input wire logic [`CORE_DATA_WIDTH-1:0] memAddr,
	input wire logic [`CORE_DATA_WIDTH-1:0] storeData,
	input wire logic [`CORE_DATA_WIDTH-1:0] din,
	output logic [`CORE_DATA_WIDTH-1:0] addr,
	output logic [`CORE_DATA_WIDTH-1:0] dout,
	output logic rdN,
	output logic wrN,
	output logic [`CORE_DATA_WIDTH-1:0] instrWord,
	output logic [`CORE_DATA_WIDTH-1:0] loadData
);

	logic isLoad;
	logic isStore;
	logic [`CORE_DATA_WIDTH-1:0] instrReg;

	assign isLoad = execute && (memOp == memLoad);
	assign isStore = execute && (memOp == memStore);

	// the pc is on the bus unless a load or store owns the execute cycle.
	assign addr = (isLoad || isStore) ? memAddr : pc;
	assign dout = storeData;
	assign rdN = !(fetch || isLoad);
	assign wrN = !isStore;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			instrReg <= '0;
			loadData <= '0;
		end else begin
			if (fetch) instrReg <= din;
			if (isLoad) loadData <= din;
		end
	end

	// transparent during fetch so the decoder captures the word on the same edge.
	assign instrWord = fetch ? din : instrReg;

endmodule

`default_nettype wire

// ==== rtl/core.sv ====
// CPU core top level connecting sequencer, decoder, datapath and bus controller.
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module core
	import corePkg::*;
(
	input wire logic CLK,
	input wire logic arstN,
	input wire logic [`CORE_DATA_WIDTH-1:0] din,
	output logic [`CORE_DATA_WIDTH-1:0] addr,
	output logic [`CORE_DATA_WIDTH-1:0] dout,
	output logic rdN,
	output logic wrN,
	output logic stopped
);

	localparam int regAddrWidth = $clog2(`CORE_REG_COUNT);

	logic fetch;
	logic execute;
	logic commit;
	logic haltReq;
	logic regWrite;

	groupT group;
	aluOpT aluOp;
	memOpT memOp;
	condT cond;
	logic [regAddrWidth-1:0] regA;
	logic [regAddrWidth-1:0] regB;

	logic [`CORE_DATA_WIDTH-1:0] immediate;
	logic [`CORE_DATA_WIDTH-1:0] offset;
	logic [`CORE_DATA_WIDTH-1:0] instrWord;
	logic [`CORE_DATA_WIDTH-1:0] loadData;
	logic [`CORE_DATA_WIDTH-1:0] rdDataA;
	logic [`CORE_DATA_WIDTH-1:0] rdDataB;
	logic [`CORE_DATA_WIDTH-1:0] aluResult;
	logic [`CORE_DATA_WIDTH-1:0] wrData;
	logic [`CORE_DATA_WIDTH-1:0] pc;

	logic flagZero;
	logic flagCarry;
	logic flagSign;

	// write-back source follows the memory operation.
	always_comb begin
		case (memOp)
			memLoadImm: wrData = immediate;
			memLoad: wrData = loadData;
			default: wrData = aluResult;
		endcase
	end

	// nothing acts on the decode phase itself.
	phaseSequencer phaseSequencerInst (
		.CLK(CLK), .arstN(arstN), .haltReq(haltReq),
		.fetch(fetch), .decode(), .execute(execute),
		.commit(commit), .stopped(stopped)
	);

	instructionDecoder #(.regAddrWidth(regAddrWidth)) instructionDecoderInst (
		.CLK(CLK), .arstN(arstN), .fetch(fetch), .instrWord(instrWord),
		.group(group), .aluOp(aluOp), .memOp(memOp), .cond(cond),
		.regA(regA), .regB(regB), .immediate(immediate), .offset(offset),
		.regWrite(regWrite), .haltReq(haltReq)
	);

	alu aluInst (
		.CLK(CLK), .arstN(arstN), .commit(commit),
		.aluEn(group == groupAlu), .aluOp(aluOp),
		.aData(rdDataA), .bData(rdDataB), .result(aluResult),
		.flagZero(flagZero), .flagCarry(flagCarry), .flagSign(flagSign)
	);

	registerFile #(.regAddrWidth(regAddrWidth)) registerFileInst (
		.CLK(CLK), .arstN(arstN), .wrEn(commit && regWrite),
		.wrAddr(regA), .rdAddrA(regA), .rdAddrB(regB), .wrData(wrData),
		.rdDataA(rdDataA), .rdDataB(rdDataB)
	);

	programCounter programCounterInst (
		.CLK(CLK), .arstN(arstN), .commit(commit),
		.isJump(group == groupJump), .cond(cond), .offset(offset),
		.flagZero(flagZero), .flagCarry(flagCarry), .flagSign(flagSign),
		.pc(pc)
	);

	busController busControllerInst (
		.CLK(CLK), .arstN(arstN), .fetch(fetch), .execute(execute),
		.memOp(memOp), .pc(pc), .memAddr(rdDataB), .storeData(rdDataA),
		.din(din), .addr(addr), .dout(dout), .rdN(rdN), .wrN(wrN),
		.instrWord(instrWord), .loadData(loadData)
	);

endmodule

`default_nettype wire

// ==== bench/coreChecker.sv ====
// bus monitor that checks the stores and the halt timing of the CPU core.
`timescale 1ns/10ps
`default_nettype none

module coreChecker (
	input wire logic CLK,
	input wire logic armed,
	input wire logic [15:0] addr,
	input wire logic [15:0] dout,
	input wire logic rdN,
	input wire logic wrN,
	input wire logic stopped,
	input wire logic [15:0] nextAddr,
	input wire logic [15:0] nextData,
	input wire logic [15:0] expStores,
	input wire logic [15:0] expCycles,
	output logic [15:0] storeIndex,
	output logic [15:0] errorCount,
	output logic stopChecked
);

	logic [15:0] index = '0;
	logic [15:0] errors = '0;
	logic [15:0] cycle = '0;
	logic started = 1'b0;
	logic stopSeen = 1'b0;

	assign storeIndex = index;
	assign errorCount = errors;
	assign stopChecked = stopSeen;

	// sampled on the falling edge, half a cycle after the bus settles.
	always @(negedge CLK) begin
		if (!armed) begin
			index = '0;
			cycle = '0;
			started = 1'b0;
			stopSeen = 1'b0;
		end else begin
			// cycles count from the first fetch.
			if (started) begin
				cycle = cycle + 16'd1;
			end else if (!rdN) begin
				started = 1'b1;
			end
			if (!wrN && !stopped) begin
				if (index >= expStores) begin
					$display("unexpected store of 0x%04h to 0x%04h", dout, addr);
					errors = errors + 16'd1;
				end else begin
					if (addr !== nextAddr) begin
						$display("Error: store %0d addr expected 0x%04h got 0x%04h",
							index, nextAddr, addr);
						errors = errors + 16'd1;
					end
					if (dout !== nextData) begin
						$display("Error: store %0d dout expected 0x%04h got 0x%04h",
							index, nextData, dout);
						errors = errors + 16'd1;
					end
				end
				index = index + 16'd1;
			end
			if (stopped && !stopSeen) begin
				stopSeen = 1'b1;
				if (cycle !== expCycles) begin
					$display("Error: stopped cycle expected 0x%04h got 0x%04h",
						expCycles, cycle);
					errors = errors + 16'd1;
				end
				if (index !== expStores) begin
					$display("Error: store count expected 0x%04h got 0x%04h", expStores, index);
					errors = errors + 16'd1;
				end
			end
			if (stopped && (!rdN || !wrN)) begin
				$display("bus strobe active while the core is stopped");
				errors = errors + 16'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/coreTb.sv ====
// testbench for the CPU core with memory model, reference interpreter and test programs.
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module coreTb
	import corePkg::*;
();

	logic CLK;
	logic arstN;
	logic armed;
	logic [`CORE_DATA_WIDTH-1:0] din;
	logic [`CORE_DATA_WIDTH-1:0] addr;
	logic [`CORE_DATA_WIDTH-1:0] dout;
	logic rdN;
	logic wrN;
	logic stopped;
	logic [15:0] mem [1024];
	logic [15:0] expAddr [64];
	logic [15:0] expData [64];
	logic [15:0] expStores;
	logic [15:0] expCycles;
	logic [15:0] storeIndex;
	logic [15:0] errorCount;
	logic stopChecked;
	int progLen;
	int seed;
	int passCount;
	int failCount;

	core core_inst (
		.CLK(CLK), .arstN(arstN), .din(din), .addr(addr), .dout(dout),
		.rdN(rdN), .wrN(wrN), .stopped(stopped)
	);

	coreChecker checkerInst (
		.CLK(CLK), .armed(armed), .addr(addr), .dout(dout), .rdN(rdN), .wrN(wrN),
		.stopped(stopped), .nextAddr(expAddr[storeIndex[5:0]]),
		.nextData(expData[storeIndex[5:0]]), .expStores(expStores), .expCycles(expCycles),
		.storeIndex(storeIndex), .errorCount(errorCount), .stopChecked(stopChecked)
	);

	always #20 CLK = ~CLK;

	// memory answers a moment after each edge, once addr has settled.
	always @(posedge CLK) begin
		#1;
		din = mem[addr[9:0]];
	end

	always @(negedge CLK) begin
		if (armed && !wrN) begin
			mem[addr[9:0]] = dout;
		end
	end

	function automatic logic [15:0] aluWord(aluOpT op, logic [2:0] ra, logic [2:0] rb);
		return {2'b00, op, 5'b00000, ra, rb};
	endfunction

	function automatic logic [15:0] immWord(logic [2:0] rd, logic [7:0] imm);
		return {4'b0100, 1'b0, rd, imm};
	endfunction

	function automatic logic [15:0] memWord(logic [1:0] kind, logic [2:0] ra, logic [2:0] rb);
		return {2'b01, kind, 6'b000000, ra, rb};
	endfunction

	function automatic logic [15:0] jumpWord(condT c, logic [7:0] off);
		return {2'b10, c, 4'b0000, off};
	endfunction

	task automatic emit(input logic [15:0] word);
		mem[progLen] = word;
		progLen++;
	endtask

	task automatic saveReg(input logic [2:0] r, input logic [7:0] where);
		emit(immWord(3'd7, where));
		emit(memWord(2'd2, r, 3'd7));
	endtask

	// stores 1 when the jump on c is taken and 0 when it falls through.
	task automatic markFlag(input condT c, input logic [7:0] where);
		emit(immWord(3'd0, 8'd1));
		emit(jumpWord(c, 8'd1));
		emit(immWord(3'd0, 8'd0));
		saveReg(3'd0, where);
	endtask

	// executes the loaded program by the ISA rules and fills the expected store list.
	function automatic int runInterpreter();
		logic [15:0] regs [8];
		logic [15:0] work [1024];
		logic [15:0] pcRef;
		logic [15:0] ir;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic z;
		logic c;
		logic s;
		logic taken;
		int sh;
		int count;
		for (int i = 0; i < 8; i++) regs[i] = '0;
		for (int i = 0; i < 1024; i++) work[i] = mem[i];
		pcRef = '0;
		{z, c, s} = 3'b000;
		expStores = '0;
		count = 0;
		while (count < 4000) begin
			ir = work[pcRef[9:0]];
			a = regs[ir[5:3]];
			b = regs[ir[2:0]];
			count++;
			pcRef = pcRef + 16'd1;
			case (ir[15:14])
				2'b00: begin
					sh = int'(b[3:0]);
					c = 1'b0;
					case (aluOpT'(ir[13:11]))
						aluAdd: begin
							res = a + b;
							c = (res < a);
						end
						aluSub: begin
							res = a - b;
							c = (a < b);
						end
						aluAnd: res = a & b;
						aluOr: res = a | b;
						aluXor: res = a ^ b;
						aluMov: res = b;
						aluShl: begin
							res = a << sh;
							c = (sh > 0) ? a[16-sh] : 1'b0;
						end
						default: begin
							res = a >> sh;
							c = (sh > 0) ? a[sh-1] : 1'b0;
						end
					endcase
					z = (res == 16'h0000);
					s = res[15];
					regs[ir[5:3]] = res;
				end
				2'b01: begin
					if (ir[13:12] == 2'd0) begin
						regs[ir[10:8]] = {8'h00, ir[7:0]};
					end else if (ir[13:12] == 2'd1) begin
						regs[ir[5:3]] = work[b[9:0]];
					end else if (ir[13:12] == 2'd2) begin
						work[b[9:0]] = a;
						expAddr[expStores[5:0]] = b;
						expData[expStores[5:0]] = a;
						expStores = expStores + 16'd1;
					end
				end
				2'b10: begin
					case (condT'(ir[13:12]))
						condZero: taken = z;
						condCarry: taken = c;
						condSign: taken = s;
						default: taken = 1'b1;
					endcase
					if (taken) pcRef = pcRef + {{8{ir[7]}}, ir[7:0]};
				end
				default: begin
					if (ir[13:12] == 2'd1) return count;
				end
			endcase
		end
		return -1;
	endfunction

	task automatic newProgram();
		@(posedge CLK);
		#1;
		arstN = 1'b0;
		armed = 1'b0;
		for (int i = 0; i < 1024; i++) mem[i] = 16'(i) ^ 16'h5A3C;
		progLen = 0;
	endtask

	task automatic runTest(input string name);
		int count;
		int waited;
		logic [15:0] errorsBefore;
		count = runInterpreter();
		expCycles = 16'(4 * count);
		errorsBefore = errorCount;
		for (int i = 0; i < 16; i++) @(posedge CLK);
		#1;
		arstN = 1'b1;
		armed = 1'b1;
		waited = 0;
		while (!stopped && waited < 4 * count + 64) begin
			@(posedge CLK);
			#1;
			waited++;
		end
		if (!stopped) begin
			$display("test %s: core did not stop within %0d cycles", name, waited);
			failCount++;
		end else begin
			// bus must stay idle while stopped.
			for (int i = 0; i < 8; i++) @(posedge CLK);
			if (count < 0 || !stopChecked || errorCount != errorsBefore) begin
				$display("test %s: failed, %0d errors", name, errorCount - errorsBefore);
				failCount++;
			end else begin
				$display("test %s: passed, %0d instructions", name, count);
				passCount++;
			end
		end
	endtask

	task automatic arithProgram();
		emit(immWord(3'd3, 8'd8));
		emit(immWord(3'd1, 8'hF0));
		emit(aluWord(aluShl, 3'd1, 3'd3));
		emit(immWord(3'd2, 8'h20));
		emit(aluWord(aluShl, 3'd2, 3'd3));
		// F000 + 2000 carries out.
		emit(aluWord(aluAdd, 3'd1, 3'd2));
		saveReg(3'd1, 8'h80);
		markFlag(condCarry, 8'h81);
		emit(immWord(3'd5, 8'd3));
		emit(immWord(3'd6, 8'd5));
		emit(aluWord(aluSub, 3'd5, 3'd6));
		saveReg(3'd5, 8'h82);
		markFlag(condCarry, 8'h83);
		emit(immWord(3'd5, 8'd3));
		emit(aluWord(aluSub, 3'd6, 3'd5));
		saveReg(3'd6, 8'h84);
		markFlag(condCarry, 8'h85);
		emit(16'hD000);
	endtask

	task automatic logicProgram();
		emit(immWord(3'd1, 8'hA5));
		emit(immWord(3'd2, 8'h3C));
		for (int k = 0; k < 4; k++) begin
			emit(aluWord(aluMov, 3'd3, 3'd1));
			emit(aluWord(aluOpT'(k + 2), 3'd3, 3'd2));
			saveReg(3'd3, 8'(8'h90 + k));
		end
		for (int k = 0; k < 3; k++) begin
			emit(aluWord(aluMov, 3'd3, 3'd1));
			emit(immWord(3'd4, (k == 0) ? 8'd9 : 8'(k)));
			emit(aluWord((k == 0) ? aluShl : aluShr, 3'd3, 3'd4));
			saveReg(3'd3, 8'(8'h98 + 2 * k));
			markFlag(condCarry, 8'(8'h99 + 2 * k));
		end
		emit(16'hD000);
	endtask

	task automatic memoryProgram();
		// address 0 reads back this load's own word.
		emit(memWord(2'd1, 3'd1, 3'd0));
		saveReg(3'd1, 8'hA3);
		emit(immWord(3'd1, 8'h5A));
		emit(immWord(3'd2, 8'hA0));
		emit(memWord(2'd2, 3'd1, 3'd2));
		emit(memWord(2'd1, 3'd3, 3'd2));
		emit(immWord(3'd4, 8'h11));
		emit(aluWord(aluAdd, 3'd3, 3'd4));
		emit(immWord(3'd5, 8'hA1));
		emit(memWord(2'd2, 3'd3, 3'd5));
		emit(memWord(2'd1, 3'd6, 3'd5));
		saveReg(3'd6, 8'hA2);
		emit(16'hD000);
	endtask

	task automatic loopProgram();
		int top;
		emit(immWord(3'd1, 8'd5));
		emit(immWord(3'd2, 8'd1));
		emit(immWord(3'd3, 8'd0));
		emit(immWord(3'd5, 8'hB0));
		top = progLen;
		emit(aluWord(aluAdd, 3'd3, 3'd1));
		emit(memWord(2'd2, 3'd3, 3'd5));
		emit(aluWord(aluAdd, 3'd5, 3'd2));
		emit(aluWord(aluSub, 3'd1, 3'd2));
		emit(jumpWord(condZero, 8'd1));
		emit(jumpWord(condAlways, 8'(top - progLen - 1)));
		emit(immWord(3'd4, 8'd0));
		emit(immWord(3'd6, 8'd1));
		emit(aluWord(aluSub, 3'd4, 3'd6));
		markFlag(condSign, 8'hB8);
		emit(aluWord(aluAdd, 3'd6, 3'd6));
		markFlag(condSign, 8'hB9);
		markFlag(condZero, 8'hBA);
		emit(16'hD000);
	endtask

	task automatic haltProgram();
		emit(16'hC000);
		emit(16'hC000);
		emit(immWord(3'd1, 8'h77));
		saveReg(3'd1, 8'hC0);
		emit(16'hD000);
		// never reached, a store here would show up as unexpected.
		emit(memWord(2'd2, 3'd1, 3'd7));
	endtask

	task automatic randomProgram();
		logic [31:0] r;
		for (int i = 0; i < 7; i++) begin
			r = $random(seed);
			emit(immWord(3'(i), r[7:0]));
		end
		// r7 is kept as the store address, inside 0x80..0xFF.
		for (int i = 0; i < 28; i++) begin
			r = $random(seed);
			if (r[1:0] == 2'b00) begin
				emit(immWord(3'd7, {1'b1, r[8:2]}));
				emit(memWord(2'd2, r[11:9], 3'd7));
			end else begin
				emit(aluWord(aluOpT'(r[4:2]), (r[7:5] == 3'd7) ? 3'd6 : r[7:5], r[10:8]));
			end
		end
		emit(16'hD000);
	endtask

	initial begin
		CLK = 1'b0;
		arstN = 1'b0;
		armed = 1'b0;
		din = '0;
		expStores = '0;
		expCycles = '0;
		progLen = 0;
		seed = 32'h64e5;
		passCount = 0;
		failCount = 0;
		newProgram();
		arithProgram();
		runTest("arithmetic");
		newProgram();
		logicProgram();
		runTest("logic and shifts");
		newProgram();
		memoryProgram();
		runTest("memory");
		newProgram();
		loopProgram();
		runTest("control flow");
		newProgram();
		haltProgram();
		runTest("halt");
		newProgram();
		randomProgram();
		runTest("random");
		$display("tests: %0d passed, %0d failed, %0d errors", passCount, failCount, errorCount);
		if (failCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/corePkg.sv
rtl/phaseSequencer.sv
rtl/instructionDecoder.sv
rtl/alu.sv
rtl/registerFile.sv
rtl/programCounter.sv
rtl/busController.sv
rtl/core.sv
bench/coreChecker.sv
bench/coreTb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Irtl rtl/corePkg.sv rtl/phaseSequencer.sv \
		rtl/instructionDecoder.sv rtl/alu.sv rtl/registerFile.sv \
		rtl/programCounter.sv rtl/busController.sv rtl/core.sv --top-module core

sim:
	verilator --binary --timing -f src.f --top-module coreTb -Mdir obj_dir
	@out="$$(./obj_dir/VcoreTb)"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
